// ==== hw/cache_pkg.sv ====
package cache_pkg;

    // Word address and word width
    parameter int ADDR_W = 24;
    parameter int DATA_W = 24;

    // Word offset inside a line, 16 words per line
    parameter int OFF_BITS = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Backing memory opcode
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Front request from the pipeline
    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        data_t wdata;
    } cpu_req_t;

    // Front response, one cycle after a read completes
    typedef struct packed {
        logic  valid;
        data_t rdata;
    } cpu_rsp_t;

    // Backing request, held until acknowledged
    typedef struct packed {
        logic    req;
        mem_op_e op;
        addr_t   addr;
        data_t   wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        data_t rdata;
    } mem_rsp_t;

    // Data array write, only the low line and offset bits of addr are used
    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } arr_wr_t;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_DRAIN,
        RF_FILL
    } refill_state_e;

endpackage

// ==== hw/cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store
    import cache_pkg::*;
#(
    parameter int IDX_BITS = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t addr,
    output logic  hit,
    input  logic  tag_set,
    input  addr_t set_addr
);
    localparam int TAG_BITS = ADDR_W - OFF_BITS - IDX_BITS;
    localparam int LINES = 1 << IDX_BITS;

    // One valid bit and one tag per line
    logic [LINES-1:0]    valid;
    logic [TAG_BITS-1:0] tags [LINES];

    // Front address split
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;

    // Refill address split
    logic [IDX_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] set_tag;

    assign idx     = addr[OFF_BITS +: IDX_BITS];
    assign tag     = addr[ADDR_W-1 -: TAG_BITS];
    assign set_idx = set_addr[OFF_BITS +: IDX_BITS];
    assign set_tag = set_addr[ADDR_W-1 -: TAG_BITS];

    // Combinational hit for the front address
    assign hit = valid[idx] && (tags[idx] == tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (tag_set) begin
            valid[set_idx] <= 1'b1;
        end
    end

    // Tag written together with the valid bit at the last refill beat
    always_ff @(posedge clk) begin
        if (tag_set) begin
            tags[set_idx] <= set_tag;
        end
    end

    // Refills start only from a read miss, so the line never holds this tag yet
    a_no_redundant_fill: assert property (@(posedge clk) disable iff (rst)
        tag_set |-> !(valid[set_idx] && (tags[set_idx] == set_tag)));

endmodule

// ==== hw/cache_data_store.sv ====
`timescale 1ns/1ps

module cache_data_store
    import cache_pkg::*;
#(
    parameter int IDX_BITS = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  addr_t   rd_addr,
    input  logic    rd_en,
    output data_t   rdata,
    output logic    rsp_valid,
    input  arr_wr_t wr
);
    localparam int WORD_BITS = IDX_BITS + OFF_BITS;
    localparam int WORDS = 1 << WORD_BITS;

    // Lines times words, addressed by {index, offset}
    data_t mem [WORDS];

    logic [WORD_BITS-1:0] rd_word;
    logic [WORD_BITS-1:0] wr_word;

    assign rd_word = rd_addr[WORD_BITS-1:0];
    assign wr_word = wr.addr[WORD_BITS-1:0];

    // Single write port, fed by store hits or refill beats
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_word] <= wr.data;
        end
    end

    // Registered read, word appears the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[rd_word];
        end
    end

    // Marks the cycle in which rdata carries a completed read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;
        end
    end

endmodule

// ==== hw/cache_refill_ctrl.sv ====
`timescale 1ns/1ps

module cache_refill_ctrl
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    input  logic     hit,
    input  logic     wb_busy,
    input  logic     fill_ack,
    input  data_t    fill_data,
    output logic     stall,
    output logic     rd_en,
    output arr_wr_t  arr_wr,
    output logic     tag_set,
    output addr_t    set_addr,
    output logic     fill_req,
    output addr_t    fill_addr,
    output logic     store_go
);
    refill_state_e state;
    refill_state_e state_nxt;

    // Current refill beat and the line being refilled
    logic [OFF_BITS-1:0]        beat_cnt;
    logic [ADDR_W-OFF_BITS-1:0] line_base;

    logic rd_miss;
    logic store_hit;
    logic beat_done;
    logic last_beat;

    assign rd_miss = cpu_req.valid && !cpu_req.we && !hit;

    // Request cannot complete during refill/drain, on a read miss,
    // or for a store while the buffer still holds the previous one
    assign stall = cpu_req.valid &&
                   ((state != RF_IDLE) || rd_miss || (cpu_req.we && wb_busy));

    assign rd_en     = cpu_req.valid && !cpu_req.we && !stall;
    assign store_go  = cpu_req.valid && cpu_req.we && !stall;
    assign store_hit = store_go && hit;

    // Beats are fetched in order from the line base
    assign fill_req  = (state == RF_FILL);
    assign fill_addr = {line_base, beat_cnt};
    assign beat_done = fill_req && fill_ack;
    assign last_beat = beat_done && (beat_cnt == {OFF_BITS{1'b1}});

    // Line becomes valid with the sixteenth beat
    assign tag_set  = last_beat;
    assign set_addr = {line_base, {OFF_BITS{1'b0}}};

    // Array write select
    // Refill beats and store hits never coincide, stores only complete in RF_IDLE
    always_comb begin
        arr_wr = '0;
        if (beat_done) begin
            arr_wr.en   = 1'b1;
            arr_wr.addr = fill_addr;
            arr_wr.data = fill_data;
        end else if (store_hit) begin
            arr_wr.en   = 1'b1;
            arr_wr.addr = cpu_req.addr;
            arr_wr.data = cpu_req.wdata;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            RF_IDLE: begin
                if (rd_miss) begin
                    state_nxt = RF_DRAIN;
                end
            end
            // Wait for a pending write-through to reach memory first
            RF_DRAIN: begin
                if (!wb_busy) begin
                    state_nxt = RF_FILL;
                end
            end
            RF_FILL: begin
                if (last_beat) begin
                    state_nxt = RF_IDLE;
                end
            end
            default: begin
                state_nxt = RF_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RF_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Wraps back to zero after the last beat
            if (beat_done) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Line address captured when the miss is seen
    always_ff @(posedge clk) begin
        if ((state == RF_IDLE) && rd_miss) begin
            line_base <= cpu_req.addr[ADDR_W-1:OFF_BITS];
        end
    end

    // Memory port only returns refill acknowledges while a refill is running
    a_no_ack_idle: assert property (@(posedge clk) disable iff (rst)
        fill_ack |-> (state != RF_IDLE));

endmodule

// ==== hw/cache_mem_port.sv ====
`timescale 1ns/1ps

module cache_mem_port
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     store_go,
    input  cpu_req_t cpu_req,
    input  logic     fill_req,
    input  addr_t    fill_addr,
    output logic     fill_ack,
    output data_t    fill_data,
    output logic     wb_busy,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);
    // One-entry store buffer
    logic  buf_full;
    addr_t buf_addr;
    data_t buf_data;

    assign wb_busy = buf_full;

    // Buffered store wins, fills only start once it is empty
    always_comb begin
        mem_req = '0;
        if (buf_full) begin
            mem_req.req   = 1'b1;
            mem_req.op    = MEM_WRITE;
            mem_req.addr  = buf_addr;
            mem_req.wdata = buf_data;
        end else if (fill_req) begin
            mem_req.req  = 1'b1;
            mem_req.op   = MEM_READ;
            mem_req.addr = fill_addr;
        end
    end

    // Acknowledge goes to the refill side only when no store is pending
    assign fill_ack  = mem_rsp.ack && !buf_full;
    assign fill_data = mem_rsp.rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_full <= 1'b0;
        end else if (store_go) begin
            buf_full <= 1'b1;
        end else if (mem_rsp.ack) begin
            buf_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store_go) begin
            buf_addr <= cpu_req.addr;
            buf_data <= cpu_req.wdata;
        end
    end

    // Request is held unchanged until the memory takes it
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req.req && !mem_rsp.ack) |=> $stable(mem_req));

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import cache_pkg::*;
#(
    parameter int IDX_BITS = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output logic     stall,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);
    // Tag lookup
    logic    hit;
    logic    tag_set;
    addr_t   set_addr;

    // Data array
    logic    rd_en;
    logic    rsp_valid;
    data_t   rdata;
    arr_wr_t arr_wr;

    // Refill and write-through traffic
    logic    fill_req;
    addr_t   fill_addr;
    logic    fill_ack;
    data_t   fill_data;
    logic    store_go;
    logic    wb_busy;

    // Response packed as {valid, rdata}
    assign cpu_rsp = {rsp_valid, rdata};

    cache_tag_store #(
        .IDX_BITS(IDX_BITS)
    ) tag_store0 (
        .clk     (clk),
        .rst     (rst),
        .addr    (cpu_req.addr),
        .hit     (hit),
        .tag_set (tag_set),
        .set_addr(set_addr)
    );

    cache_data_store #(
        .IDX_BITS(IDX_BITS)
    ) data_store0 (
        .clk      (clk),
        .rst      (rst),
        .rd_addr  (cpu_req.addr),
        .rd_en    (rd_en),
        .rdata    (rdata),
        .rsp_valid(rsp_valid),
        .wr       (arr_wr)
    );

    cache_refill_ctrl refill_ctrl0 (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .hit      (hit),
        .wb_busy  (wb_busy),
        .fill_ack (fill_ack),
        .fill_data(fill_data),
        .stall    (stall),
        .rd_en    (rd_en),
        .arr_wr   (arr_wr),
        .tag_set  (tag_set),
        .set_addr (set_addr),
        .fill_req (fill_req),
        .fill_addr(fill_addr),
        .store_go (store_go)
    );

    cache_mem_port mem_port0 (
        .clk      (clk),
        .rst      (rst),
        .store_go (store_go),
        .cpu_req  (cpu_req),
        .fill_req (fill_req),
        .fill_addr(fill_addr),
        .fill_ack (fill_ack),
        .fill_data(fill_data),
        .wb_busy  (wb_busy),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

endmodule

// ==== tests/tb_backing_mem.sv ====
`timescale 1ns/1ps

module tb_backing_mem
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);
    // Reference copy of memory, only words that were written are stored
    data_t ref_mem [addr_t];

    // Fixed seed for the acknowledge delays
    integer seed = 32'hae3b7aaa;

    // Cycles to wait for the present request, and cycles waited so far
    logic [1:0] delay;
    logic [1:0] wait_cnt;
    logic       xfer;

    // Untouched words, odd multiplier keeps every address distinct
    function automatic data_t fill_word(addr_t a);
        return (a * 24'h00a3b5) ^ 24'h5c3e91;
    endfunction

    function automatic data_t word_at(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return fill_word(a);
    endfunction

    // Delay 0 acknowledges in the first cycle of the request
    assign xfer = mem_req.req && (wait_cnt == delay);

    always_comb begin
        mem_rsp.ack   = xfer;
        mem_rsp.rdata = word_at(mem_req.addr);
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
            delay    <= '0;
        end else if (xfer) begin
            // Write-through lands in the reference copy
            if (mem_req.op == MEM_WRITE) begin
                ref_mem[mem_req.addr] = mem_req.wdata;
            end
            wait_cnt <= '0;
            delay    <= 2'($random(seed));
        end else if (mem_req.req) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

endmodule

// ==== tests/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache
    import cache_pkg::*;
();
    localparam int IDX_BITS = 4;
    localparam int NUM_STEPS = 11;
    // Worst step is a refill of 16 beats at up to 4 cycles each
    localparam int TIMEOUT_CYCLES = NUM_STEPS * 80;

    // One table row, op tells a load from a store
    typedef struct packed {
        mem_op_e op;
        addr_t   addr;
        data_t   wdata;
        data_t   exp_data;
        int      exp_reads;
    } step_t;

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    logic     stall;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    step_t    steps [NUM_STEPS];
    // Backing transfers seen during the current step
    mem_req_t rd_q [$];
    mem_req_t wr_q [$];
    int       cycles = 0;
    int       errors = 0;

    dcache_top #(
        .IDX_BITS(IDX_BITS)
    ) dut0 (
        .clk    (clk),
        .rst    (rst),
        .cpu_req(cpu_req),
        .cpu_rsp(cpu_rsp),
        .stall  (stall),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    tb_backing_mem mem0 (
        .clk    (clk),
        .rst    (rst),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Initial memory contents, same rule as the backing model
    function automatic data_t fill_word(addr_t a);
        return (a * 24'h00a3b5) ^ 24'h5c3e91;
    endfunction

    function automatic step_t make_step(mem_op_e op, addr_t addr, data_t wdata,
                                        data_t exp_data, int exp_reads);
        step_t s;
        s.op        = op;
        s.addr      = addr;
        s.wdata     = wdata;
        s.exp_data  = exp_data;
        s.exp_reads = exp_reads;
        return s;
    endfunction

    // Lines 0x01234x and 0x77774x share index 4, line 0x05678x sits at index 8
    task automatic load_table();
        steps[0]  = make_step(MEM_READ, 24'h012343, '0, fill_word(24'h012343), 16);
        steps[1]  = make_step(MEM_READ, 24'h01234a, '0, fill_word(24'h01234a), 0);
        // Store hit, then read back from the array
        steps[2]  = make_step(MEM_WRITE, 24'h012345, 24'habcdef, '0, 0);
        steps[3]  = make_step(MEM_READ, 24'h012345, '0, 24'habcdef, 0);
        // Store miss goes to memory only
        steps[4]  = make_step(MEM_WRITE, 24'h056780, 24'h13579b, '0, 0);
        steps[5]  = make_step(MEM_READ, 24'h056780, '0, 24'h13579b, 16);
        // Conflict pair evicting each other
        steps[6]  = make_step(MEM_READ, 24'h77774c, '0, fill_word(24'h77774c), 16);
        steps[7]  = make_step(MEM_READ, 24'h012345, '0, 24'habcdef, 16);
        steps[8]  = make_step(MEM_READ, 24'h77774c, '0, fill_word(24'h77774c), 16);
        steps[9]  = make_step(MEM_READ, 24'h012343, '0, fill_word(24'h012343), 16);
        steps[10] = make_step(MEM_READ, 24'h056781, '0, fill_word(24'h056781), 0);
    endtask

    task automatic stop_run(input string msg);
        errors = errors + 1;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // Write data only matters for MEM_WRITE
    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got.req !== exp.req || got.op !== exp.op || got.addr !== exp.addr ||
            (exp.op == MEM_WRITE && got.wdata !== exp.wdata)) begin
            stop_run($sformatf("ERR %0t %s got %s addr %h data %h expected %s addr %h data %h",
                $time, name, (got.op == MEM_WRITE) ? "write" : "read", got.addr, got.wdata,
                (exp.op == MEM_WRITE) ? "write" : "read", exp.addr, exp.wdata));
        end
    endtask

    task automatic run_step(input step_t s);
        cpu_req_t req;
        mem_req_t exp_req;
        addr_t    base;
        rd_q.delete();
        wr_q.delete();
        req.valid = 1'b1;
        req.we    = (s.op == MEM_WRITE);
        req.addr  = s.addr;
        req.wdata = s.wdata;
        @(posedge clk);
        cpu_req <= req;
        // Held until stall drops, completes at the next rising edge
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        cpu_req <= '0;
        @(negedge clk);
        if (s.op == MEM_READ) begin
            check_flag("cpu_rsp.valid", cpu_rsp.valid, 1'b1);
            check_data("cpu_rsp.rdata", cpu_rsp.rdata, s.exp_data);
            @(posedge clk);
            check_count("mem_read_count", rd_q.size(), s.exp_reads);
            check_count("mem_write_count", wr_q.size(), 0);
            // Beats from the line base upward
            base = {s.addr[ADDR_W-1:OFF_BITS], {OFF_BITS{1'b0}}};
            for (int k = 0; k < rd_q.size(); k++) begin
                exp_req      = '0;
                exp_req.req  = 1'b1;
                exp_req.op   = MEM_READ;
                exp_req.addr = base + addr_t'(k);
                check_req("mem_req", rd_q[k], exp_req);
            end
        end else begin
            // No response for stores
            check_flag("cpu_rsp.valid", cpu_rsp.valid, 1'b0);
            do begin
                @(posedge clk);
            end while (wr_q.size() == 0);
            // Buffer empties with its acknowledge, so the port goes quiet
            @(negedge clk);
            check_flag("mem_req.req", mem_req.req, 1'b0);
            check_count("mem_read_count", rd_q.size(), 0);
            exp_req       = '0;
            exp_req.req   = 1'b1;
            exp_req.op    = MEM_WRITE;
            exp_req.addr  = s.addr;
            exp_req.wdata = s.wdata;
            check_req("mem_req", wr_q[0], exp_req);
        end
    endtask

    // Transfer happens at the next rising edge, fields are settled here
    always @(negedge clk) begin
        if (!rst && mem_req.req && mem_rsp.ack) begin
            if (mem_req.op == MEM_READ) begin
                rd_q.push_back(mem_req);
            end else begin
                wr_q.push_back(mem_req);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout after %0d cycles, the test table did not finish",
                cycles));
        end
    end

    initial begin
        rst     = 1'b1;
        cpu_req = '0;
        load_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("stall", stall, 1'b0);
        check_flag("cpu_rsp.valid", cpu_rsp.valid, 1'b0);
        check_flag("mem_req.req", mem_req.req, 1'b0);
        @(posedge clk);
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(steps[i]);
        end
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_refill_ctrl.sv
hw/cache_mem_port.sv
hw/dcache_top.sv
tests/tb_backing_mem.sv
tests/tb_dcache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module tb_dcache -o sim_dcache
out=$(./obj_dir/sim_dcache 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1
